// File: Makefile
SRCS := $(wildcard logic/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vgolf_game_tb: $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module golf_game_tb -f vlog.f

run: obj_dir/Vgolf_game_tb
	./obj_dir/Vgolf_game_tb > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/aim_control.sv
`timescale 1ns/1ps
`default_nettype none

module aim_control #(
    parameter int ANGLE_STEP_CYCLES = 1111111
) (
    input  logic                   clk_in,
    input  logic                   arst_n,
    input  logic                   pan_left,
    input  logic                   pan_right,
    input  logic                   user_rdy,
    input  golf_fixed_pkg::fix_t   user_input,
    output golf_fixed_pkg::angle_t cam_angle,
    output golf_game_pkg::shot_t   shot
);

    localparam int CNT_W = $clog2(ANGLE_STEP_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ANGLE_STEP_CYCLES - 1);
    localparam golf_fixed_pkg::angle_t ANGLE_MAX = 16'(golf_fixed_pkg::ANGLE_FULL - 1);

    logic             pan_one;   // Exactly one button held
    logic             pan_step;  // Hold period complete
    logic [CNT_W-1:0] hold_cnt;

    assign pan_one  = pan_left ^ pan_right;
    assign pan_step = pan_one && (hold_cnt == CNT_LAST);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt <= '0;
        end else if (!pan_one || pan_step) begin
            hold_cnt <= '0;  // Release, both held, or step taken
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            cam_angle <= '0;
        end else if (pan_step) begin
            if (pan_left) begin
                cam_angle <= (cam_angle == ANGLE_MAX) ? '0 : cam_angle + 1'b1;
            end else begin
                cam_angle <= (cam_angle == '0) ? ANGLE_MAX : cam_angle - 1'b1;
            end
        end
    end

    // Shot is the registered user request
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            shot <= '0;
        end else begin
            shot.fire  <= user_rdy;
            shot.speed <= user_input;
        end
    end

endmodule

`default_nettype wire

// File: logic/ball_physics.sv
`timescale 1ns/1ps
`default_nettype none

module ball_physics #(
    parameter int START_X = 4,
    parameter int START_Y = 4
) (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  logic                       new_frame,
    input  golf_fixed_pkg::angle_t     cam_angle,
    input  golf_game_pkg::shot_t       shot,
    input  golf_game_pkg::probe_t      probe,
    input  golf_game_pkg::trig_t       trig,
    output golf_game_pkg::ball_t       ball,
    output golf_game_pkg::game_state_e state,
    output logic                       stroke
);

    logic                   wall_vertical;  // Last wall was found on an x probe
    logic [23:0]            prod_x, prod_y;
    golf_fixed_pkg::fix_t   step_x, step_y;
    golf_fixed_pkg::fix_t   decel;
    golf_fixed_pkg::fix_t   speed_dec;
    golf_fixed_pkg::angle_t dir_vertical;
    golf_fixed_pkg::angle_t dir_horizontal;

    // Per-frame displacement is (speed * magnitude) >> 8
    assign prod_x = 24'(ball.speed) * 24'(trig.cos_mag);
    assign prod_y = 24'(ball.speed) * 24'(trig.sin_mag);
    assign step_x = prod_x[23:8];
    assign step_y = prod_y[23:8];

    always_comb begin
        case (probe.centre)
            golf_game_pkg::grass: decel = golf_fixed_pkg::GRASS_DECEL;
            golf_game_pkg::sand:  decel = golf_fixed_pkg::SAND_DECEL;
            default:              decel = '0;  // No friction on hole or wall
        endcase
    end

    assign speed_dec = (ball.speed > decel) ? ball.speed - decel : '0;

    // Reflected directions (180 - d) mod 360 and (360 - d) mod 360
    assign dir_vertical = (ball.direction <= 16'd180) ? 16'd180 - ball.direction
                                                      : 16'd540 - ball.direction;
    assign dir_horizontal = (ball.direction == '0) ? '0
                          : 16'(golf_fixed_pkg::ANGLE_FULL) - ball.direction;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state          <= golf_game_pkg::resting;
            ball.pos_x     <= {8'(START_X), 8'h00};
            ball.pos_y     <= {8'(START_Y), 8'h00};
            ball.speed     <= '0;
            ball.direction <= '0;
            wall_vertical  <= 1'b0;
            stroke         <= 1'b0;
        end else begin
            stroke <= 1'b0;
            case (state)
                golf_game_pkg::resting: begin
                    ball.direction <= cam_angle;  // Aim follows the camera
                    if (shot.fire) begin
                        ball.speed <= shot.speed;
                        stroke     <= 1'b1;
                        state      <= golf_game_pkg::moving;
                    end
                end

                golf_game_pkg::moving: begin
                    if (new_frame) begin
                        if (probe.centre == golf_game_pkg::hole &&
                            ball.speed < golf_fixed_pkg::HOLE_SPEED) begin
                            ball.pos_x[7:0] <= golf_fixed_pkg::HOLE_FRACTION;
                            ball.pos_y[7:0] <= golf_fixed_pkg::HOLE_FRACTION;
                            state           <= golf_game_pkg::in_hole;
                        end else if (ball.speed == '0) begin
                            state <= golf_game_pkg::resting;
                        end else if (probe.x_plus == golf_game_pkg::wall) begin
                            ball.pos_x    <= {ball.pos_x[15:8], 8'h00};  // Snap left
                            wall_vertical <= 1'b1;
                            state         <= golf_game_pkg::wall_hit;
                        end else if (probe.y_plus == golf_game_pkg::wall) begin
                            ball.pos_y    <= {ball.pos_y[15:8], 8'h00};
                            wall_vertical <= 1'b0;
                            state         <= golf_game_pkg::wall_hit;
                        end else if (probe.x_minus == golf_game_pkg::wall) begin
                            ball.pos_x    <= {ball.pos_x[15:8] + 8'd1, 8'h00};
                            wall_vertical <= 1'b1;
                            state         <= golf_game_pkg::wall_hit;
                        end else if (probe.y_minus == golf_game_pkg::wall) begin
                            ball.pos_y    <= {ball.pos_y[15:8] + 8'd1, 8'h00};
                            wall_vertical <= 1'b0;
                            state         <= golf_game_pkg::wall_hit;
                        end else begin
                            ball.speed <= speed_dec;
                            ball.pos_x <= trig.cos_neg ? ball.pos_x - step_x
                                                       : ball.pos_x + step_x;
                            ball.pos_y <= trig.sin_neg ? ball.pos_y - step_y
                                                       : ball.pos_y + step_y;
                        end
                    end
                end

                golf_game_pkg::wall_hit: begin
                    if (new_frame) begin
                        ball.direction <= wall_vertical ? dir_vertical : dir_horizontal;
                        state          <= golf_game_pkg::moving;
                    end
                end

                golf_game_pkg::in_hole: begin
                    // Ball stays centred in the cup until reset
                    ball.pos_x[7:0] <= golf_fixed_pkg::HOLE_FRACTION;
                    ball.pos_y[7:0] <= golf_fixed_pkg::HOLE_FRACTION;
                end

                default: state <= golf_game_pkg::resting;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/golf_fixed_pkg.sv
`default_nettype none

package golf_fixed_pkg;

    typedef logic [15:0] fix_t;    // 8.8 unsigned, positions and speeds
    typedef logic [15:0] angle_t;  // Whole degrees, 0 to 359

    localparam int ANGLE_FULL = 360;

    // Speed loss per frame, in speed LSBs
    localparam fix_t GRASS_DECEL = 16'd2;
    localparam fix_t SAND_DECEL  = 16'd10;

    localparam fix_t HOLE_SPEED   = 16'h0080;  // Ball drops below 0.5 per frame
    localparam fix_t PROBE_OFFSET = 16'h0070;  // Edge probes sit 0.44 tile out

    localparam logic [7:0] HOLE_FRACTION = 8'h80;  // Centre of the hole tile

    localparam int TRIG_STEP = 5;    // Degrees per table entry
    localparam int TRIG_ONE  = 256;  // Table value for 1.0

endpackage

`default_nettype wire

// File: logic/golf_game.sv
`timescale 1ns/1ps
`default_nettype none

module golf_game #(
    parameter int MAP_W             = 32,
    parameter int MAP_H             = 32,
    parameter int START_X           = 4,
    parameter int START_Y           = 4,
    parameter int ANGLE_STEP_CYCLES = 1111111
) (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  logic                       pan_left,
    input  logic                       pan_right,
    input  logic                       new_frame,
    input  logic                       user_rdy,
    input  golf_fixed_pkg::fix_t       user_input,
    input  logic                       map_we,
    input  logic [15:0]                map_addr,
    input  golf_game_pkg::terrain_e    map_data,
    output golf_game_pkg::ball_t       ball,
    output golf_fixed_pkg::angle_t     cam_angle,
    output logic [7:0]                 score,
    output golf_game_pkg::game_state_e game_state
);

    golf_game_pkg::shot_t       shot;
    golf_game_pkg::probe_t      probe;
    golf_game_pkg::trig_t       trig;
    golf_game_pkg::ball_t       ball_next;   // Live ball from the FSM
    golf_game_pkg::game_state_e state_next;
    logic                       stroke;

    aim_control #(
        .ANGLE_STEP_CYCLES(ANGLE_STEP_CYCLES)
    ) u_aim_control (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .pan_left  (pan_left),
        .pan_right (pan_right),
        .user_rdy  (user_rdy),
        .user_input(user_input),
        .cam_angle (cam_angle),
        .shot      (shot)
    );

    terrain_probe #(
        .MAP_W(MAP_W),
        .MAP_H(MAP_H)
    ) u_terrain_probe (
        .clk_in  (clk_in),
        .map_we  (map_we),
        .map_addr(map_addr),
        .map_data(map_data),
        .ball    (ball_next),
        .probe   (probe)
    );

    trig_lookup u_trig_lookup (
        .clk_in   (clk_in),
        .direction(ball_next.direction),
        .trig     (trig)
    );

    ball_physics #(
        .START_X(START_X),
        .START_Y(START_Y)
    ) u_ball_physics (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .new_frame(new_frame),
        .cam_angle(cam_angle),
        .shot     (shot),
        .probe    (probe),
        .trig     (trig),
        .ball     (ball_next),
        .state    (state_next),
        .stroke   (stroke)
    );

    scorecard u_scorecard (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .ball_next (ball_next),
        .state     (state_next),
        .stroke    (stroke),
        .ball      (ball),
        .game_state(game_state),
        .score     (score)
    );

endmodule

`default_nettype wire

// File: logic/golf_game_pkg.sv
`default_nettype none

package golf_game_pkg;

    typedef enum logic [1:0] {
        hole  = 2'd0,
        wall  = 2'd1,
        grass = 2'd2,
        sand  = 2'd3
    } terrain_e;

    typedef enum logic [1:0] {
        resting  = 2'd0,
        moving   = 2'd1,
        wall_hit = 2'd2,
        in_hole  = 2'd3
    } game_state_e;

    typedef struct packed {
        golf_fixed_pkg::fix_t   pos_x;
        golf_fixed_pkg::fix_t   pos_y;
        golf_fixed_pkg::fix_t   speed;      // Distance per frame
        golf_fixed_pkg::angle_t direction;  // 0 is +x, 90 is +y
    } ball_t;

    // Terrain under the ball centre and at the four edge points
    typedef struct packed {
        terrain_e centre;
        terrain_e x_plus;
        terrain_e y_plus;
        terrain_e x_minus;
        terrain_e y_minus;
    } probe_t;

    typedef struct packed {
        logic                 fire;
        golf_fixed_pkg::fix_t speed;
    } shot_t;

    typedef struct packed {
        logic [8:0] cos_mag;  // 0 to 256
        logic [8:0] sin_mag;
        logic       cos_neg;
        logic       sin_neg;
    } trig_t;

endpackage

`default_nettype wire

// File: logic/scorecard.sv
`timescale 1ns/1ps
`default_nettype none

module scorecard (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  golf_game_pkg::ball_t       ball_next,
    input  golf_game_pkg::game_state_e state,
    input  logic                       stroke,
    output golf_game_pkg::ball_t       ball,
    output golf_game_pkg::game_state_e game_state,
    output logic [7:0]                 score
);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            score      <= '0;
            game_state <= golf_game_pkg::resting;
        end else begin
            if (stroke && score != 8'hFF) begin
                score <= score + 8'd1;  // Saturates at 255
            end
            game_state <= state;
        end
    end

    // Registered ball for the game outputs
    always_ff @(posedge clk_in) begin
        ball <= ball_next;
    end

endmodule

`default_nettype wire

// File: logic/terrain_probe.sv
`timescale 1ns/1ps
`default_nettype none

module terrain_probe #(
    parameter int MAP_W = 32,
    parameter int MAP_H = 32
) (
    input  logic                    clk_in,
    input  logic                    map_we,
    input  logic [15:0]             map_addr,
    input  golf_game_pkg::terrain_e map_data,
    input  golf_game_pkg::ball_t    ball,
    output golf_game_pkg::probe_t   probe
);

    localparam int DEPTH  = MAP_W * MAP_H;
    localparam int ADDR_W = $clog2(DEPTH);

    golf_game_pkg::terrain_e course_mem [DEPTH];

    golf_fixed_pkg::fix_t x_hi, x_lo, y_hi, y_lo;  // Edge probe coordinates
    logic [15:0]          addr_c, addr_xp, addr_yp, addr_xm, addr_ym;

    // Row major tile index from the integer parts
    function automatic logic [15:0] tile_addr(input golf_fixed_pkg::fix_t x,
                                              input golf_fixed_pkg::fix_t y);
        logic [15:0] row_base;
        row_base = 16'(y[15:8] * 16'(MAP_W));
        return row_base + 16'(x[15:8]);
    endfunction

    assign x_hi = ball.pos_x + golf_fixed_pkg::PROBE_OFFSET;
    assign x_lo = ball.pos_x - golf_fixed_pkg::PROBE_OFFSET;
    assign y_hi = ball.pos_y + golf_fixed_pkg::PROBE_OFFSET;
    assign y_lo = ball.pos_y - golf_fixed_pkg::PROBE_OFFSET;

    assign addr_c  = tile_addr(ball.pos_x, ball.pos_y);
    assign addr_xp = tile_addr(x_hi, ball.pos_y);
    assign addr_yp = tile_addr(ball.pos_x, y_hi);
    assign addr_xm = tile_addr(x_lo, ball.pos_y);
    assign addr_ym = tile_addr(ball.pos_x, y_lo);

    always_ff @(posedge clk_in) begin
        if (map_we) begin
            course_mem[map_addr[ADDR_W-1:0]] <= map_data;  // Course load port
        end
        probe.centre  <= course_mem[addr_c[ADDR_W-1:0]];
        probe.x_plus  <= course_mem[addr_xp[ADDR_W-1:0]];
        probe.y_plus  <= course_mem[addr_yp[ADDR_W-1:0]];
        probe.x_minus <= course_mem[addr_xm[ADDR_W-1:0]];
        probe.y_minus <= course_mem[addr_ym[ADDR_W-1:0]];
    end

endmodule

`default_nettype wire

// File: logic/trig_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module trig_lookup (
    input  logic                   clk_in,
    input  golf_fixed_pkg::angle_t direction,
    output golf_game_pkg::trig_t   trig
);

    // round(256 * sin(5 * k degrees)), k = 0 to 18
    localparam logic [8:0] SIN_TABLE [19] = '{
        9'd0,   9'd22,  9'd44,  9'd66,  9'd88,
        9'd108, 9'd128, 9'd147, 9'd165, 9'd181,
        9'd196, 9'd210, 9'd222, 9'd232, 9'd241,
        9'd247, 9'd252, 9'd255, 9'(golf_fixed_pkg::TRIG_ONE)
    };

    logic [1:0]  quadrant;
    logic [15:0] quarter;      // Reference angle, 0 to 90
    logic [15:0] quarter_co;   // Complementary angle
    logic [4:0]  sin_idx;
    logic [4:0]  cos_idx;

    always_comb begin
        if (direction < 16'd90) begin
            quadrant = 2'd0;
            quarter  = direction;
        end else if (direction < 16'd180) begin
            quadrant = 2'd1;
            quarter  = 16'd180 - direction;
        end else if (direction < 16'd270) begin
            quadrant = 2'd2;
            quarter  = direction - 16'd180;
        end else begin
            quadrant = 2'd3;
            quarter  = 16'(golf_fixed_pkg::ANGLE_FULL) - direction;
        end
    end

    assign quarter_co = 16'd90 - quarter;
    assign sin_idx    = 5'(quarter / 16'(golf_fixed_pkg::TRIG_STEP));
    assign cos_idx    = 5'(quarter_co / 16'(golf_fixed_pkg::TRIG_STEP));

    always_ff @(posedge clk_in) begin
        trig.sin_mag <= SIN_TABLE[sin_idx];
        trig.cos_mag <= SIN_TABLE[cos_idx];
        trig.cos_neg <= (quadrant == 2'd1) || (quadrant == 2'd2);  // Pointing -x
        trig.sin_neg <= quadrant[1];                                // Pointing -y
    end

endmodule

`default_nettype wire

// File: tests/golf_game_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module golf_game_asserts (
    input wire logic                       clk_in,
    input wire logic                       arst_n,
    input wire golf_fixed_pkg::angle_t     cam_angle,
    input wire logic [7:0]                 score,
    input wire golf_game_pkg::game_state_e game_state
);

    a_cam_range: assert property (@(posedge clk_in) disable iff (!arst_n)
        cam_angle < 16'd360)
        else $error("cam_angle left the 0 to 359 range");

    // Score only counts up, one stroke at a time
    a_score_step: assert property (@(posedge clk_in) disable iff (!arst_n)
        (score >= $past(score)) && (score - $past(score) <= 8'd1))
        else $error("score dropped or jumped by more than one");

    a_hole_held: assert property (@(posedge clk_in) disable iff (!arst_n)
        game_state == golf_game_pkg::in_hole |=> game_state == golf_game_pkg::in_hole)
        else $error("game_state left in_hole without reset");

endmodule

bind golf_game golf_game_asserts u_golf_game_asserts (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .cam_angle (cam_angle),
    .score     (score),
    .game_state(game_state)
);

`default_nettype wire

// File: tests/golf_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module golf_game_tb;

    localparam int MAP_W       = 32;
    localparam int MAP_H       = 32;
    localparam int STEP_CYC    = 4;
    localparam int MAX_FRAMES  = 150;
    localparam int FRAME_CYC   = 4;    // Strobe cycle plus 3 settle cycles
    localparam int SHOTS       = 5;
    localparam int PAN_CYC     = 124 + 360 + 120 + 40;
    localparam int LIMIT       = MAP_W * MAP_H + PAN_CYC + SHOTS * (MAX_FRAMES + 2) * FRAME_CYC
                                 + 5 * 10 + 2000;

    typedef struct packed {
        golf_game_pkg::ball_t       ball;
        golf_game_pkg::game_state_e state;
        logic                       vert;  // Last wall was vertical
    } model_t;

    logic                       clk_in = 1'b0;
    logic                       arst_n;
    logic                       pan_left, pan_right, new_frame, user_rdy, map_we;
    golf_fixed_pkg::fix_t       user_input;
    logic [15:0]                map_addr;
    golf_game_pkg::terrain_e    map_data;
    golf_game_pkg::ball_t       ball;
    golf_fixed_pkg::angle_t     cam_angle;
    logic [7:0]                 score;
    golf_game_pkg::game_state_e game_state;

    golf_game_pkg::terrain_e course [MAP_W*MAP_H];
    int          sin_tab [19];
    model_t      m;
    int          exp_cam, exp_score;
    int          errors, tests_run, cycles;
    int          sand_frames, wall_hits;
    logic        saw_150;
    logic [15:0] lfsr = 16'd41102;

    golf_game #(
        .MAP_W(MAP_W), .MAP_H(MAP_H), .START_X(4), .START_Y(4),
        .ANGLE_STEP_CYCLES(STEP_CYC)
    ) u_golf_game (
        .clk_in(clk_in), .arst_n(arst_n), .pan_left(pan_left), .pan_right(pan_right),
        .new_frame(new_frame), .user_rdy(user_rdy), .user_input(user_input),
        .map_we(map_we), .map_addr(map_addr), .map_data(map_data), .ball(ball),
        .cam_angle(cam_angle), .score(score), .game_state(game_state)
    );

    always #4 clk_in = ~clk_in;  // 8 ns period

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    function automatic golf_game_pkg::terrain_e tile_at(logic [15:0] x, logic [15:0] y);
        int idx;
        idx = (int'(y[15:8]) * MAP_W + int'(x[15:8])) % (MAP_W * MAP_H);
        return course[idx];
    endfunction

    // Expected ball after one frame strobe
    function automatic model_t model_frame(model_t cur);
        model_t                  n;
        golf_game_pkg::terrain_e c;
        golf_fixed_pkg::fix_t    x, y, sp, dec, sx, sy;
        int                      d, q, sm, cm;
        n  = cur;
        x  = cur.ball.pos_x;
        y  = cur.ball.pos_y;
        sp = cur.ball.speed;
        d  = cur.ball.direction;
        c  = tile_at(x, y);
        case (cur.state)
            golf_game_pkg::moving: begin
                if (c == golf_game_pkg::hole && sp < 16'h0080) begin
                    n.ball.pos_x[7:0] = 8'h80;
                    n.ball.pos_y[7:0] = 8'h80;
                    n.state = golf_game_pkg::in_hole;
                end else if (sp == 0) begin
                    n.state = golf_game_pkg::resting;
                end else if (tile_at(x + 16'h70, y) == golf_game_pkg::wall) begin
                    n.ball.pos_x = {x[15:8], 8'h00};
                    n.vert = 1'b1;
                    n.state = golf_game_pkg::wall_hit;
                end else if (tile_at(x, y + 16'h70) == golf_game_pkg::wall) begin
                    n.ball.pos_y = {y[15:8], 8'h00};
                    n.vert = 1'b0;
                    n.state = golf_game_pkg::wall_hit;
                end else if (tile_at(x - 16'h70, y) == golf_game_pkg::wall) begin
                    n.ball.pos_x = {x[15:8] + 8'd1, 8'h00};
                    n.vert = 1'b1;
                    n.state = golf_game_pkg::wall_hit;
                end else if (tile_at(x, y - 16'h70) == golf_game_pkg::wall) begin
                    n.ball.pos_y = {y[15:8] + 8'd1, 8'h00};
                    n.vert = 1'b0;
                    n.state = golf_game_pkg::wall_hit;
                end else begin
                    dec = (c == golf_game_pkg::grass) ? 16'd2 :
                          (c == golf_game_pkg::sand) ? 16'd10 : 16'd0;
                    if (d <= 90) q = d;
                    else if (d <= 180) q = 180 - d;
                    else if (d <= 270) q = d - 180;
                    else q = 360 - d;
                    sm = sin_tab[q / 5];
                    cm = sin_tab[(90 - q) / 5];
                    sx = 16'((int'(sp) * cm) >> 8);
                    sy = 16'((int'(sp) * sm) >> 8);
                    n.ball.pos_x = (d > 90 && d < 270) ? x - sx : x + sx;
                    n.ball.pos_y = (d > 180) ? y - sy : y + sy;
                    n.ball.speed = (sp > dec) ? sp - dec : 16'd0;
                end
            end
            golf_game_pkg::wall_hit: begin
                n.ball.direction = cur.vert ? 16'(((180 - d) % 360 + 360) % 360)
                                            : 16'((360 - d) % 360);
                n.state = golf_game_pkg::moving;
            end
            default: ;
        endcase
        if (n.state == golf_game_pkg::resting) n.ball.direction = 16'(exp_cam);
        return n;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_all();
        check("ball.pos_x", ball.pos_x, m.ball.pos_x);
        check("ball.pos_y", ball.pos_y, m.ball.pos_y);
        check("ball.speed", ball.speed, m.ball.speed);
        check("ball.direction", ball.direction, m.ball.direction);
        check("game_state", game_state, m.state);
        check("score", score, exp_score);
    endtask

    task automatic reset_all();
        arst_n = 1'b0;
        repeat (10) @(posedge clk_in);
        #1 arst_n = 1'b1;
        m = '{ball: '{pos_x: 16'h0400, pos_y: 16'h0400, speed: 0, direction: 0},
              state: golf_game_pkg::resting, vert: 1'b0};
        exp_cam   = 0;
        exp_score = 0;
    endtask

    task automatic load_course();
        golf_game_pkg::terrain_e t;
        for (int y = 0; y < MAP_H; y++) begin
            for (int x = 0; x < MAP_W; x++) begin
                if (x == 0 || y == 0 || x == MAP_W - 1 || y == MAP_H - 1) begin
                    t = golf_game_pkg::wall;
                end else if (x >= 10 && x <= 12) begin
                    t = golf_game_pkg::sand;
                end else if (x == 20 && y == 4) begin
                    t = golf_game_pkg::hole;
                end else begin
                    t = golf_game_pkg::grass;
                end
                course[y*MAP_W + x] = t;
                map_we   = 1'b1;
                map_addr = 16'(y*MAP_W + x);
                map_data = t;
                @(posedge clk_in);
                #1;
            end
        end
        map_we = 1'b0;
    endtask

    // Hold buttons for n edges, then let the ball output catch up
    task automatic pan(input logic left, input logic right, input int n);
        pan_left  = left;
        pan_right = right;
        repeat (n) @(posedge clk_in);
        #1;
        pan_left  = 1'b0;
        pan_right = 1'b0;
        if (left ^ right) begin
            exp_cam = exp_cam + (left ? 1 : -1) * (n / STEP_CYC);
            exp_cam = (exp_cam % 360 + 360) % 360;
        end
        repeat (3) @(posedge clk_in);
        #1;
        m.ball.direction = 16'(exp_cam);
    endtask

    task automatic fire_shot(input int speed);
        user_rdy   = 1'b1;
        user_input = 16'(speed);
        @(posedge clk_in);
        #1 user_rdy = 1'b0;
        repeat (3) @(posedge clk_in);
        #1;
        m.state      = golf_game_pkg::moving;
        m.ball.speed = 16'(speed);
        exp_score++;
        compare_all();
    endtask

    task automatic frame();
        new_frame = 1'b1;
        @(posedge clk_in);
        #1 new_frame = 1'b0;
        repeat (3) @(posedge clk_in);
        #1;
    endtask

    task automatic play_until_stop();
        model_t prev;
        int     i;
        for (i = 0; i < MAX_FRAMES; i++) begin
            prev = m;
            frame();
            m = model_frame(m);
            compare_all();
            if (prev.state == golf_game_pkg::moving &&
                tile_at(prev.ball.pos_x, prev.ball.pos_y) == golf_game_pkg::sand) sand_frames++;
            if (m.state == golf_game_pkg::wall_hit) wall_hits++;
            if (prev.state == golf_game_pkg::wall_hit && ball.direction == 16'd150) begin
                saw_150 = 1'b1;
            end
            if (m.state == golf_game_pkg::resting || m.state == golf_game_pkg::in_hole) break;
        end
        if (i == MAX_FRAMES) begin
            errors++;
            $display("Ball did not stop within %0d frames", MAX_FRAMES);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "mismatches found");
    endtask

    initial begin
        int e0, v;
        arst_n      = 1'b0;
        pan_left    = 1'b0;
        pan_right   = 1'b0;
        new_frame   = 1'b0;
        user_rdy    = 1'b0;
        user_input  = '0;
        map_we      = 1'b0;
        map_addr    = '0;
        map_data    = golf_game_pkg::grass;
        errors      = 0;
        tests_run   = 0;
        cycles      = 0;
        sand_frames = 0;
        wall_hits   = 0;
        saw_150     = 1'b0;
        for (int k = 0; k < 19; k++) begin
            sin_tab[k] = $rtoi(256.0 * $sin(5.0 * k * 3.14159265358979 / 180.0) + 0.5);
        end
        #1;
        reset_all();
        load_course();

        e0 = errors;  // Camera pan
        pan(1'b1, 1'b0, 40);
        check("cam_angle", cam_angle, 10);
        pan(1'b0, 1'b1, 40);
        pan(1'b0, 1'b1, 4);
        check("cam_angle", cam_angle, 359);
        pan(1'b1, 1'b1, 40);
        check("cam_angle", cam_angle, 359);
        report_test("Camera pan", e0);

        e0 = errors;  // Straight shots over grass
        reset_all();
        take_bits(5, v);
        fire_shot(16'h20 + v);
        play_until_stop();
        pan(1'b1, 1'b0, 90 * STEP_CYC);
        take_bits(5, v);
        fire_shot(16'h20 + v);
        play_until_stop();
        report_test("Straight shots", e0);

        e0 = errors;  // Across the sand band
        reset_all();
        sand_frames = 0;
        fire_shot(16'h90);
        play_until_stop();
        if (sand_frames == 0) begin
            errors++;
            $display("Ball never rolled over sand");
        end
        report_test("Sand", e0);

        e0 = errors;  // Into the right wall
        reset_all();
        wall_hits = 0;
        saw_150 = 1'b0;
        pan(1'b1, 1'b0, 30 * STEP_CYC);
        fire_shot(16'hEC);
        play_until_stop();
        if (wall_hits == 0 || !saw_150) begin
            errors++;
            $display("Ball did not bounce off the right wall to 150 degrees");
        end
        report_test("Wall bounce", e0);

        e0 = errors;  // Slow shot into the cup
        reset_all();
        fire_shot(16'hC0);
        play_until_stop();
        frame();
        compare_all();
        check("game_state", game_state, golf_game_pkg::in_hole);
        check("ball.pos_x[7:0]", ball.pos_x[7:0], 8'h80);
        check("ball.pos_y[7:0]", ball.pos_y[7:0], 8'h80);
        check("score", score, 1);
        report_test("Hole", e0);

        $display("Tests %0d, errors %0d, cycles %0d", tests_run, errors, cycles);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/golf_fixed_pkg.sv
logic/golf_game_pkg.sv
logic/aim_control.sv
logic/terrain_probe.sv
logic/trig_lookup.sv
logic/ball_physics.sv
logic/scorecard.sv
logic/golf_game.sv
tests/golf_game_asserts.sv
tests/golf_game_tb.sv
